//--- source/sdmacBusPkg.sv
`default_nettype none

package sdmacBusPkg;

    // 32-bit bus address
    typedef logic [31:0] addrT;

    // One longword on the data bus
    typedef logic [31:0] longT;

    // Cycles counted inside one bus tenure
    typedef logic [2:0] burstCountT;

    // Bus cycle states of the CPU side
    typedef enum logic [2:0] {
        busIdle,
        busRequest,
        busOwned,
        busAddrPhase,
        busDataPhase,
        busTermWait,
        busRecover,
        busRelease
    } busStateT;

    // Most longwords moved before the bus is given back
    localparam int burstLimit = 4;

    // Address step of one longword cycle
    localparam addrT addrStep = 32'd4;

endpackage

`default_nettype wire

//--- source/sdmacFifoPkg.sv
`default_nettype none

package sdmacFifoPkg;

    // Entries in the longword FIFO
    localparam int fifoDepth = 8;

    // Read and write pointers wrap on their own at depth 8
    typedef logic [2:0] fifoPtrT;

    // Fill level from 0 up to 8
    typedef logic [3:0] fifoCountT;

    // One device word
    typedef logic [15:0] halfT;

endpackage

`default_nettype wire

//--- source/cpuBusSm.sv
`timescale 1ns/1ps
`default_nettype none

module cpuBusSm
    import sdmacBusPkg::*;
(
    input  wire        BBCLK,
    input  wire        CCRESET_,
    input  wire        dmaEna,
    input  wire        dmaDir,
    input  wire addrT  startAddr,
    input  wire        flushFifo,
    input  wire        busGrant,
    input  wire        dsAck,
    input  wire        sTerm,
    input  wire longT  dataIn,
    input  wire longT  fifoRdData,
    input  wire        empty,
    input  wire        full,
    input  wire        partialValid,
    output logic       busReq,
    output logic       bgAck,
    output addrT       addr,
    output longT       dataOut,
    output logic       rw,
    output logic       addrStrobe,
    output logic       dataStrobe,
    output logic       fifoPop,
    output logic       fifoPush,
    output longT       fifoWrData,
    output logic       padReq,
    output logic       stopFlush
);

    busStateT   state;
    busStateT   nextState;
    burstCountT beatCount;
    addrT       addrReg;
    longT       writeData;
    longT       readData;
    logic       flushDone;
    logic       acked;
    logic       hasWork;
    logic       flushActive;
    logic       loadAddr;

    // Either termination ends the data phase
    assign acked = dsAck || sTerm;

    // Flush only makes sense toward memory
    assign flushActive = flushFifo && !dmaDir;

    // Write side drains while enabled or flushing
    // Read side fills while enabled and room is left
    assign hasWork = dmaDir ? (dmaEna && !full) : (!empty && (dmaEna || flushActive));

    // Start address only taken while parked and disabled
    assign loadAddr = !dmaEna && !flushFifo && (state == busIdle);

    always_comb begin
        nextState = state;
        unique case (state)
            busIdle: begin
                if (hasWork) begin
                    nextState = busRequest;
                end
            end
            // Hold the request until the arbiter answers
            busRequest: begin
                if (busGrant) begin
                    nextState = busOwned;
                end
            end
            busOwned: begin
                nextState = hasWork ? busAddrPhase : busRelease;
            end
            busAddrPhase: begin
                nextState = busDataPhase;
            end
            // Wait states until dsAck or sTerm
            busDataPhase: begin
                if (acked) begin
                    nextState = busTermWait;
                end
            end
            busTermWait: begin
                nextState = busRecover;
            end
            // Another cycle only if work is left and the burst is not used up
            busRecover: begin
                if (hasWork && (beatCount < burstCountT'(burstLimit))) begin
                    nextState = busAddrPhase;
                end else begin
                    nextState = busRelease;
                end
            end
            busRelease: begin
                nextState = busIdle;
            end
            default: begin
                nextState = busIdle;
            end
        endcase
    end

    always_ff @(posedge BBCLK or negedge CCRESET_) begin
        if (!CCRESET_) begin
            state     <= busIdle;
            beatCount <= '0;
            addrReg   <= '0;
            flushDone <= 1'b0;
        end else begin
            state <= nextState;
            // Fresh burst count per tenure
            if (state == busOwned) begin
                beatCount <= '0;
            end else if ((state == busDataPhase) && acked) begin
                beatCount <= beatCount + 1'b1;
            end
            if (loadAddr) begin
                addrReg <= startAddr;
            end else if ((state == busDataPhase) && acked) begin
                addrReg <= addrReg + addrStep;
            end
            // One stop pulse per flush request
            if (!flushFifo) begin
                flushDone <= 1'b0;
            end else if (stopFlush) begin
                flushDone <= 1'b1;
            end
        end
    end

    always_ff @(posedge BBCLK) begin
        // Head of FIFO latched as the cycle opens
        if (nextState == busAddrPhase) begin
            writeData <= fifoRdData;
        end
        // Read data taken on the terminating edge
        if ((state == busDataPhase) && acked) begin
            readData <= dataIn;
        end
    end

    // Bus ownership decoded from the state
    assign busReq     = (state == busRequest);
    assign bgAck      = state inside {busOwned, busAddrPhase, busDataPhase,
                                      busTermWait, busRecover};
    assign addrStrobe = state inside {busAddrPhase, busDataPhase};
    assign dataStrobe = (state == busDataPhase);

    assign addr    = addrReg;
    assign dataOut = writeData;
    // Idle bus direction parks as read
    assign rw      = bgAck ? dmaDir : 1'b1;

    // FIFO moves one cycle after the acknowledge
    assign fifoPop    = (state == busTermWait) && !dmaDir;
    assign fifoPush   = (state == busTermWait) && dmaDir;
    assign fifoWrData = readData;

    // Pad the waiting half once every full longword is out
    assign padReq    = flushActive && (state == busIdle) && empty && partialValid;
    assign stopFlush = flushActive && !flushDone && (state == busIdle) && empty
                       && !partialValid;

    // Strobes need a grant that was already held the cycle before
    strobeInTenure: assert property (@(posedge BBCLK) disable iff (!CCRESET_)
        (addrStrobe || dataStrobe) |-> (bgAck && $past(bgAck)));

    // Write data pops only from a filled FIFO
    popNotEmpty: assert property (@(posedge BBCLK) disable iff (!CCRESET_)
        fifoPop |-> !empty);

endmodule

`default_nettype wire

//--- source/dmaFifo.sv
`timescale 1ns/1ps
`default_nettype none

module dmaFifo
    import sdmacBusPkg::*;
    import sdmacFifoPkg::*;
(
    input  wire        BBCLK,
    input  wire        CCRESET_,
    input  wire        push,
    input  wire longT  wrData,
    input  wire        pop,
    output longT       rdData,
    output logic       full,
    output logic       empty,
    output fifoCountT  count
);

    longT      mem [fifoDepth];
    fifoPtrT   wrPtr;
    fifoPtrT   rdPtr;
    fifoCountT nextCount;

    // Level after this edge
    always_comb begin
        nextCount = count;
        case ({push, pop})
            2'b10: nextCount = count + 1'b1;
            2'b01: nextCount = count - 1'b1;
            default: nextCount = count;
        endcase
    end

    always_ff @(posedge BBCLK or negedge CCRESET_) begin
        if (!CCRESET_) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
            full  <= 1'b0;
            empty <= 1'b1;
        end else begin
            if (push) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            count <= nextCount;
            // Flags registered from the next level
            full  <= (nextCount == fifoCountT'(fifoDepth));
            empty <= (nextCount == '0);
        end
    end

    // Storage
    always_ff @(posedge BBCLK) begin
        if (push) begin
            mem[wrPtr] <= wrData;
        end
    end

    // Head entry shows ahead of the pop
    assign rdData = mem[rdPtr];

    // Writers hold off on full
    noPushFull: assert property (@(posedge BBCLK) disable iff (!CCRESET_)
        push |-> !full);

    // Readers hold off on empty
    noPopEmpty: assert property (@(posedge BBCLK) disable iff (!CCRESET_)
        pop |-> !empty);

endmodule

`default_nettype wire

//--- source/scsiWordPort.sv
`timescale 1ns/1ps
`default_nettype none

module scsiWordPort
    import sdmacBusPkg::*;
    import sdmacFifoPkg::*;
(
    input  wire        BBCLK,
    input  wire        CCRESET_,
    input  wire        dmaEna,
    input  wire        dmaDir,
    input  wire        dreq,
    input  wire halfT  scsiDataIn,
    input  wire        full,
    input  wire        empty,
    input  wire longT  fifoRdData,
    input  wire        padReq,
    output logic       dack,
    output halfT       scsiDataOut,
    output logic       fifoPush,
    output logic       fifoPop,
    output longT       fifoWrData,
    output logic       partialValid
);

    // High half stored toward memory
    // High half already handed out toward the device
    logic halfPending;
    // Blocks back-to-back dack
    logic dackGap;
    halfT highHalf;
    logic takeWord;
    logic giveWord;
    logic padNow;

    // Zero-padded push of a lone high half
    assign padNow = !dmaDir && padReq && halfPending && !full;

    // Second word of a pair needs FIFO room
    // Padding has the write port to itself
    assign takeWord = dmaEna && !dmaDir && dreq && !dackGap && !padReq
                      && (!halfPending || !full);

    // Device reads straight off the FIFO head
    assign giveWord = dmaEna && dmaDir && dreq && !dackGap && !empty;

    assign dack = takeWord || giveWord;

    // Longword goes in with the low half or the pad
    assign fifoPush   = (takeWord && halfPending) || padNow;
    assign fifoWrData = {highHalf, (padNow ? halfT'(0) : scsiDataIn)};

    // Entry retires with its low half
    assign fifoPop     = giveWord && halfPending;
    assign scsiDataOut = halfPending ? fifoRdData[15:0] : fifoRdData[31:16];

    // Only a write-side half counts as waiting data
    assign partialValid = halfPending && !dmaDir;

    always_ff @(posedge BBCLK or negedge CCRESET_) begin
        if (!CCRESET_) begin
            halfPending <= 1'b0;
            dackGap     <= 1'b0;
        end else begin
            dackGap <= dack;
            if (padNow) begin
                halfPending <= 1'b0;
            end else if (dack) begin
                halfPending <= !halfPending;
            end else if (dmaDir && !dmaEna) begin
                // Half-read longword dropped when reads stop
                halfPending <= 1'b0;
            end
        end
    end

    // First word of each pair
    always_ff @(posedge BBCLK) begin
        if (takeWord && !halfPending) begin
            highHalf <= scsiDataIn;
        end
    end

endmodule

`default_nettype wire

//--- source/sdmacCore.sv
`timescale 1ns/1ps
`default_nettype none

module sdmacCore
    import sdmacBusPkg::*;
    import sdmacFifoPkg::*;
(
    input  wire        BBCLK,
    input  wire        CCRESET_,
    // Transfer control
    input  wire        dmaEna,
    input  wire        dmaDir,
    input  wire addrT  startAddr,
    input  wire        flushFifo,
    output logic       stopFlush,
    // CPU bus
    output logic       busReq,
    input  wire        busGrant,
    output logic       bgAck,
    output addrT       addr,
    output longT       dataOut,
    input  wire longT  dataIn,
    output logic       rw,
    output logic       addrStrobe,
    output logic       dataStrobe,
    input  wire        dsAck,
    input  wire        sTerm,
    // Device side
    input  wire        dreq,
    output logic       dack,
    input  wire halfT  scsiDataIn,
    output halfT       scsiDataOut
);

    // Shared FIFO ports
    logic fifoPush;
    logic fifoPop;
    longT fifoWrData;
    longT fifoRdData;
    logic full;
    logic empty;

    // Bus side requests
    logic busPush;
    logic busPop;
    longT busWrData;

    // Device side requests
    logic portPush;
    logic portPop;
    longT portWrData;

    logic partialValid;
    logic padReq;

    // Read direction fills from the bus and write direction from the device
    assign fifoPush   = dmaDir ? busPush : portPush;
    assign fifoPop    = dmaDir ? portPop : busPop;
    assign fifoWrData = dmaDir ? busWrData : portWrData;

    cpuBusSm busSm (
        .BBCLK        (BBCLK),
        .CCRESET_     (CCRESET_),
        .dmaEna       (dmaEna),
        .dmaDir       (dmaDir),
        .startAddr    (startAddr),
        .flushFifo    (flushFifo),
        .busGrant     (busGrant),
        .dsAck        (dsAck),
        .sTerm        (sTerm),
        .dataIn       (dataIn),
        .fifoRdData   (fifoRdData),
        .empty        (empty),
        .full         (full),
        .partialValid (partialValid),
        .busReq       (busReq),
        .bgAck        (bgAck),
        .addr         (addr),
        .dataOut      (dataOut),
        .rw           (rw),
        .addrStrobe   (addrStrobe),
        .dataStrobe   (dataStrobe),
        .fifoPop      (busPop),
        .fifoPush     (busPush),
        .fifoWrData   (busWrData),
        .padReq       (padReq),
        .stopFlush    (stopFlush)
    );

    // Longword FIFO between the bus and the device port
    dmaFifo fifo (
        .BBCLK    (BBCLK),
        .CCRESET_ (CCRESET_),
        .push     (fifoPush),
        .wrData   (fifoWrData),
        .pop      (fifoPop),
        .rdData   (fifoRdData),
        .full     (full),
        .empty    (empty),
        .count    ()
    );

    scsiWordPort wordPort (
        .BBCLK        (BBCLK),
        .CCRESET_     (CCRESET_),
        .dmaEna       (dmaEna),
        .dmaDir       (dmaDir),
        .dreq         (dreq),
        .scsiDataIn   (scsiDataIn),
        .full         (full),
        .empty        (empty),
        .fifoRdData   (fifoRdData),
        .padReq       (padReq),
        .dack         (dack),
        .scsiDataOut  (scsiDataOut),
        .fifoPush     (portPush),
        .fifoPop      (portPop),
        .fifoWrData   (portWrData),
        .partialValid (partialValid)
    );

endmodule

`default_nettype wire

//--- bench/memSlaveModel.sv
`timescale 1ns/1ps
`default_nettype none

module memSlaveModel
    import sdmacBusPkg::*;
#(
    parameter int seedValue = 27,
    parameter int memWords  = 1024
)(
    input  wire        BBCLK,
    input  wire        busReq,
    output logic       busGrant,
    input  wire addrT  addr,
    input  wire longT  wrData,
    output longT       rdData,
    input  wire        rw,
    input  wire        dataStrobe,
    output logic       dsAck,
    output logic       sTerm
);

    // Longword storage indexed by addr[11:2]
    longT        store [memWords];
    logic [31:0] lcgState;
    int          grantWait;
    int          ackWait;
    logic        reqSeen;
    logic        strobeSeen;
    logic        ackSeen;
    logic        rwSeen;
    addrT        addrSeen;
    longT        dataSeen;

    // Delay of 0 up to span-1 cycles from the upper LCG bits
    function automatic int drawDelay(input int span);
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return int'(lcgState[30:16]) % span;
    endfunction

    initial begin
        lcgState  = seedValue;
        busGrant  = 1'b0;
        dsAck     = 1'b0;
        sTerm     = 1'b0;
        rdData    = '0;
        grantWait = drawDelay(4);
        ackWait   = drawDelay(4);
    end

    always @(posedge BBCLK) begin
        // Bus as seen on this edge
        reqSeen    = busReq;
        strobeSeen = dataStrobe;
        ackSeen    = dsAck || sTerm;
        rwSeen     = rw;
        addrSeen   = addr;
        dataSeen   = wrData;
        #1;
        // Arbiter grants after a random wait and drops once taken
        if (busGrant) begin
            busGrant  = 1'b0;
            grantWait = drawDelay(4);
        end else if (reqSeen) begin
            if (grantWait == 0) begin
                busGrant = 1'b1;
            end else begin
                grantWait = grantWait - 1;
            end
        end
        // Cycle ended on this edge so write data lands now
        if (ackSeen) begin
            if (!rwSeen) begin
                store[addrSeen[11:2]] = dataSeen;
            end
            dsAck   = 1'b0;
            sTerm   = 1'b0;
            ackWait = drawDelay(4);
        end else if (strobeSeen) begin
            if (ackWait == 0) begin
                // Either termination picked at random
                if (drawDelay(2) == 0) begin
                    dsAck = 1'b1;
                end else begin
                    sTerm = 1'b1;
                end
                if (rwSeen) begin
                    rdData = store[addrSeen[11:2]];
                end
            end else begin
                ackWait = ackWait - 1;
            end
        end
    end

endmodule

`default_nettype wire

//--- bench/sdmacCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module sdmacCoreTb
    import sdmacBusPkg::*;
    import sdmacFifoPkg::*;
();

    localparam int   writeWords = 64;
    localparam int   flushWords = 15;
    localparam int   readWords  = 48;
    localparam int   cycleLimit = 40 * (writeWords + flushWords + readWords);
    localparam int   memWords   = 1024;
    localparam addrT writeBase  = 32'h0000_0100;
    localparam addrT flushBase  = 32'h0000_0400;
    localparam addrT readBase   = 32'h0000_0800;

    logic BBCLK = 1'b0;
    logic CCRESET_;
    logic dmaEna;
    logic dmaDir;
    addrT startAddr;
    logic flushFifo;
    logic stopFlush;
    logic busReq;
    logic busGrant;
    logic bgAck;
    addrT addr;
    longT dataOut;
    longT dataIn;
    logic rw;
    logic addrStrobe;
    logic dataStrobe;
    logic dsAck;
    logic sTerm;
    logic dreq;
    logic dack;
    halfT scsiDataIn;
    halfT scsiDataOut;

    logic [31:0] lcgState   = 32'd27;
    int          checkCount = 0;
    int          errorCount = 0;
    int          cycleCount = 0;
    int          beatCount  = 0;
    int          writesDone = 0;
    int          readsDone  = 0;
    int          dsAckEnds  = 0;
    int          sTermEnds  = 0;
    int          stopPulses = 0;
    int          writesAtStop = 0;
    // Set on the edge that ends a bus cycle
    logic        ackLast    = 1'b0;
    // Words taken by the port in order
    halfT        wordLog [$];
    // Halves the device should receive
    halfT        expectHalves [$];

    always #50 BBCLK = ~BBCLK;

    sdmacCore dut (.*);

    memSlaveModel #(.seedValue(27), .memWords(memWords)) busSlave (
        .BBCLK      (BBCLK),
        .busReq     (busReq),
        .busGrant   (busGrant),
        .addr       (addr),
        .wrData     (dataOut),
        .rdData     (dataIn),
        .rw         (rw),
        .dataStrobe (dataStrobe),
        .dsAck      (dsAck),
        .sTerm      (sTerm)
    );

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState;
    endfunction

    // Preload value that spreads every address bit
    function automatic longT fillPattern(input addrT a);
        return (a * 32'h9E37_79B1) ^ 32'h5A5A_C3C3;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("Mismatch at %0t ns: %s expected %h actual %h", $time, name,
                     expected, actual);
        end
    endtask

    task automatic checkQuiet();
        checkValue("busReq", 0, busReq);
        checkValue("bgAck", 0, bgAck);
        checkValue("addrStrobe", 0, addrStrobe);
        checkValue("dataStrobe", 0, dataStrobe);
        checkValue("dack", 0, dack);
        checkValue("stopFlush", 0, stopFlush);
    endtask

    task automatic idleCycles(input int n);
        repeat (n) @(posedge BBCLK);
        #1;
    endtask

    // Device side of the write direction with random dreq gaps
    task automatic sendWords(input int total);
        int          taken;
        logic [31:0] r;
        halfT        nextWord;
        taken = 0;
        r = nextRandom();
        nextWord = r[31:16];
        scsiDataIn = nextWord;
        while (taken < total) begin
            r = nextRandom();
            // About one idle cycle in four
            dreq = (r[29:28] != 2'b00);
            @(posedge BBCLK);
            if (dack) begin
                wordLog.push_back(scsiDataIn);
                taken++;
                r = nextRandom();
                nextWord = r[31:16];
            end
            #1;
            scsiDataIn = nextWord;
        end
        dreq = 1'b0;
    endtask

    // Device side of the read direction
    task automatic receiveWords(input int total);
        int          got;
        logic [31:0] r;
        got = 0;
        while (got < total) begin
            r = nextRandom();
            dreq = (r[29:28] != 2'b00);
            @(posedge BBCLK);
            if (dack) begin
                checkValue("scsiDataOut", expectHalves.pop_front(), scsiDataOut);
                got++;
            end
            #1;
        end
        dreq = 1'b0;
    endtask

    task automatic waitBusQuiet(input int writeTarget);
        while ((writesDone < writeTarget) || busReq || bgAck) @(posedge BBCLK);
        #1;
    endtask

    // Words pair high then low
    // A lone last word gets a zero low half
    task automatic checkMemory(input addrT base, input int longs);
        longT expected;
        for (int k = 0; k < longs; k++) begin
            if (2 * k + 1 < wordLog.size()) begin
                expected = {wordLog[2 * k], wordLog[2 * k + 1]};
            end else begin
                expected = {wordLog[2 * k], 16'h0000};
            end
            checkValue("memory longword", expected, busSlave.store[(base >> 2) + k]);
        end
    endtask

    // Bus protocol watch with counters moving on the edge
    always @(posedge BBCLK) begin
        cycleCount <= cycleCount + 1;
        if (CCRESET_) begin
            if (addrStrobe || dataStrobe) begin
                checkValue("bgAck during strobes", 1, bgAck);
            end
            // Strobes drop one cycle after the ending edge
            if (ackLast) begin
                checkValue("addrStrobe after acknowledge", 0, addrStrobe);
                checkValue("dataStrobe after acknowledge", 0, dataStrobe);
            end
            ackLast <= bgAck && dataStrobe && (dsAck || sTerm);
            if (!bgAck) begin
                beatCount <= 0;
            end else if (dataStrobe && (dsAck || sTerm)) begin
                beatCount <= beatCount + 1;
                checkValue("tenure within burstLimit", 1, beatCount < burstLimit);
                if (rw) begin
                    readsDone <= readsDone + 1;
                end else begin
                    writesDone <= writesDone + 1;
                end
                if (dsAck) begin
                    dsAckEnds <= dsAckEnds + 1;
                end else begin
                    sTermEnds <= sTermEnds + 1;
                end
            end
            if (stopFlush) begin
                stopPulses   <= stopPulses + 1;
                writesAtStop <= writesDone;
            end
        end
    end

    initial begin
        wait (cycleCount >= cycleLimit);
        $display("Timeout: transfers still running after %0d cycles", cycleLimit);
        $display("Checks run: %0d, errors: %0d", checkCount, errorCount + 1);
        $display("test failed");
        $finish;
    end

    initial begin
        longT pattern;
        CCRESET_   = 1'b0;
        dmaEna     = 1'b0;
        dmaDir     = 1'b0;
        startAddr  = writeBase;
        flushFifo  = 1'b0;
        dreq       = 1'b0;
        scsiDataIn = '0;
        for (int i = 0; i < memWords; i++) begin
            busSlave.store[i] = fillPattern(addrT'(i) << 2);
        end
        // First edge still clears the flops
        for (int i = 0; i < 10; i++) begin
            @(posedge BBCLK);
            if (i > 0) begin
                checkQuiet();
            end
        end
        #1;
        CCRESET_ = 1'b1;
        repeat (5) begin
            @(posedge BBCLK);
            checkQuiet();
        end
        #1;
        // Device to memory
        dmaEna = 1'b1;
        sendWords(writeWords);
        waitBusQuiet(writeWords / 2);
        checkMemory(writeBase, writeWords / 2);
        // Odd word count then flush
        dmaEna = 1'b0;
        startAddr = flushBase;
        wordLog.delete();
        idleCycles(2);
        dmaEna = 1'b1;
        sendWords(flushWords);
        flushFifo = 1'b1;
        while (stopPulses == 0) @(posedge BBCLK);
        idleCycles(4);
        checkValue("stopFlush pulses", 1, stopPulses);
        checkValue("writes before stopFlush", writeWords / 2 + (flushWords + 1) / 2,
                   writesAtStop);
        checkMemory(flushBase, (flushWords + 1) / 2);
        flushFifo = 1'b0;
        dmaEna = 1'b0;
        // Memory to device with the high half first
        dmaDir = 1'b1;
        startAddr = readBase;
        for (int k = 0; k < readWords / 2; k++) begin
            pattern = fillPattern(readBase + addrT'(4 * k));
            expectHalves.push_back(pattern[31:16]);
            expectHalves.push_back(pattern[15:0]);
        end
        idleCycles(2);
        dmaEna = 1'b1;
        receiveWords(readWords);
        dmaEna = 1'b0;
        waitBusQuiet(0);
        checkValue("dsAck endings seen", 1, dsAckEnds > 0);
        checkValue("sTerm endings seen", 1, sTermEnds > 0);
        checkValue("reads completed", 1, readsDone >= readWords / 2);
        $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sdmacCore.f
source/sdmacBusPkg.sv
source/sdmacFifoPkg.sv
source/cpuBusSm.sv
source/dmaFifo.sv
source/scsiWordPort.sv
source/sdmacCore.sv
bench/memSlaveModel.sv
bench/sdmacCoreTb.sv

//--- Bender.yml
package:
  name: sdmac_core

sources:
  # Packages first, then the blocks, then the top level
  - files:
      - source/sdmacBusPkg.sv
      - source/sdmacFifoPkg.sv
      - source/cpuBusSm.sv
      - source/dmaFifo.sv
      - source/scsiWordPort.sv
      - source/sdmacCore.sv
  - target: test
    files:
      - bench/memSlaveModel.sv
      - bench/sdmacCoreTb.sv
